//--- common/rv_isa_pkg.sv
// RV32 instruction set constants
`default_nettype none

package rv_isa_pkg;

    // ==================================================
    // Widths and field positions
    // ==================================================
    localparam int INSTR_W    = 32;
    localparam int OPCODE_W   = 7;
    localparam int REG_IDX_W  = 5;

    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;

    // ==================================================
    // Major opcodes that carry an immediate
    // ==================================================
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // Immediate layouts
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

`default_nettype wire

//--- common/frontend_pkg.sv
// Frontend widths and stage payloads
`default_nettype none

package frontend_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] imm_t;

    // ==================================================
    // Program counter
    // ==================================================
    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t PC_STEP  = 32'd4;

    // ==================================================
    // Instruction queue sizing
    // ==================================================
    localparam int IQ_DEPTH = 32;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
    typedef logic [IQ_PTR_W:0]   iq_count_t;   // Holds 0..IQ_DEPTH

    // One fetch and one decode may still be in flight when fetch stops
    localparam int IQ_ALMOST_FULL = IQ_DEPTH - 2;

    // ==================================================
    // Stage payloads
    // ==================================================
    typedef struct packed {
        addr_t              pc;
        rv_isa_pkg::instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t                pc;
        rv_isa_pkg::instr_t   instr;
        imm_t                 imm;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        logic                 has_dest;   // rd is not x0
    } decoded_instr_t;

endpackage

`default_nettype wire

//--- fetch/fetch_unit.sv
// Sequential instruction fetch
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      redirect_i,
    input  frontend_pkg::addr_t      redirect_target_i,
    input  wire                      iq_almost_full_i,

    output logic                     imem_req_valid_o,
    output frontend_pkg::addr_t      imem_req_addr_o,
    input  wire                      imem_req_ready_i,
    input  wire                      imem_resp_valid_i,
    input  rv_isa_pkg::instr_t       imem_resp_data_i,

    output logic                     fetch_valid_o,
    output frontend_pkg::fetch_pkt_t fetch_pkt_o
);

    typedef enum logic [1:0] {
        IDLE,   // Held off by a nearly full queue
        REQ,    // Request on the bus
        WAIT    // One request outstanding
    } fetch_state_e;

    fetch_state_e             state_q, state_d;
    frontend_pkg::addr_t      pc_q, pc_d;      // Address of the next fetch
    frontend_pkg::addr_t      req_addr_q;      // Address of the request on the bus
    logic                     discard_q, discard_d;
    logic                     req_fire;
    logic                     resp_keep;
    logic                     fetch_valid_q;
    frontend_pkg::fetch_pkt_t fetch_pkt_q;

    assign imem_req_valid_o = (state_q == REQ);
    assign imem_req_addr_o  = req_addr_q;

    assign req_fire  = imem_req_valid_o && imem_req_ready_i;
    // Response belongs to the current stream
    assign resp_keep = (state_q == WAIT) && imem_resp_valid_i && !discard_q && !redirect_i;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        state_d   = state_q;
        pc_d      = pc_q;
        discard_d = discard_q;

        case (state_q)
            IDLE: begin
                // A redirect also empties the queue
                if (!iq_almost_full_i || redirect_i) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (req_fire) begin
                    state_d   = WAIT;
                    discard_d = redirect_i;   // Accepted on the redirect edge
                end else if (redirect_i) begin
                    state_d = IDLE;           // Drop the stale request
                end
            end
            WAIT: begin
                if (imem_resp_valid_i) begin
                    discard_d = 1'b0;
                    if (resp_keep) begin
                        pc_d = pc_q + frontend_pkg::PC_STEP;
                    end
                    if (resp_keep && iq_almost_full_i) begin
                        state_d = IDLE;
                    end else begin
                        state_d = REQ;
                    end
                end else if (redirect_i) begin
                    discard_d = 1'b1;   // Late response gets dropped
                end
            end
            default: state_d = IDLE;
        endcase

        if (redirect_i) begin
            pc_d = redirect_target_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= REQ;   // First request right after reset
            pc_q       <= frontend_pkg::RESET_PC;
            req_addr_q <= frontend_pkg::RESET_PC;
            discard_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            pc_q      <= pc_d;
            discard_q <= discard_d;
            if (state_d == REQ && state_q != REQ) begin
                req_addr_q <= pc_d;
            end
        end
    end

    // ==================================================
    // Fetch packet to decode
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid_q     <= 1'b0;
            fetch_pkt_q.pc    <= frontend_pkg::RESET_PC;
            fetch_pkt_q.instr <= rv_isa_pkg::NOP_INSTR;
        end else begin
            fetch_valid_q <= resp_keep;
            if (resp_keep) begin
                fetch_pkt_q.pc    <= req_addr_q;
                fetch_pkt_q.instr <= imem_resp_data_i;
            end
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_pkt_o   = fetch_pkt_q;

endmodule

`default_nettype wire

//--- decode/instr_decode.sv
// Field and immediate decode stage
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          flush_i,

    input  wire                          fetch_valid_i,
    input  frontend_pkg::fetch_pkt_t     fetch_pkt_i,

    output logic                         dec_valid_o,
    output frontend_pkg::decoded_instr_t dec_o
);

    rv_isa_pkg::instr_t           instr;
    rv_isa_pkg::opcode_t          opcode;
    rv_isa_pkg::imm_fmt_e         imm_fmt;
    frontend_pkg::imm_t           imm;
    frontend_pkg::decoded_instr_t dec_d;
    frontend_pkg::decoded_instr_t dec_q;
    logic                         dec_valid_q;

    assign instr  = fetch_pkt_i.instr;
    assign opcode = instr[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];

    // ==================================================
    // Immediate format select
    // ==================================================
    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_JALR:   imm_fmt = rv_isa_pkg::IMM_I;
            rv_isa_pkg::OPC_STORE:  imm_fmt = rv_isa_pkg::IMM_S;
            rv_isa_pkg::OPC_BRANCH: imm_fmt = rv_isa_pkg::IMM_B;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:  imm_fmt = rv_isa_pkg::IMM_U;
            rv_isa_pkg::OPC_JAL:    imm_fmt = rv_isa_pkg::IMM_J;
            default:                imm_fmt = rv_isa_pkg::IMM_NONE;
        endcase
    end

    // Sign bit is always instr[31]
    always_comb begin
        case (imm_fmt)
            rv_isa_pkg::IMM_I:
                imm = {{20{instr[31]}}, instr[31:20]};
            rv_isa_pkg::IMM_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_isa_pkg::IMM_B:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rv_isa_pkg::IMM_U:
                imm = {instr[31:12], 12'h000};
            rv_isa_pkg::IMM_J:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // ==================================================
    // Register fields
    // ==================================================
    always_comb begin
        dec_d.pc       = fetch_pkt_i.pc;
        dec_d.instr    = instr;
        dec_d.imm      = imm;
        dec_d.rd       = instr[rv_isa_pkg::RD_LSB  +: rv_isa_pkg::REG_IDX_W];
        dec_d.rs1      = instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_IDX_W];
        dec_d.rs2      = instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_IDX_W];
        dec_d.has_dest = (dec_d.rd != '0);   // x0 writes are dropped
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_q    <= 1'b0;
            dec_q.pc       <= frontend_pkg::RESET_PC;
            dec_q.instr    <= rv_isa_pkg::NOP_INSTR;
            dec_q.imm      <= '0;
            dec_q.rd       <= '0;
            dec_q.rs1      <= '0;
            dec_q.rs2      <= '0;
            dec_q.has_dest <= 1'b0;
        end else begin
            dec_valid_q <= fetch_valid_i && !flush_i;
            if (fetch_valid_i) begin
                dec_q <= dec_d;
            end
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

endmodule

`default_nettype wire

//--- queue/instr_queue.sv
// Decoded instruction queue
`timescale 1ns/1ns
`default_nettype none

module instr_queue (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          flush_i,

    input  wire                          enq_valid_i,
    input  frontend_pkg::decoded_instr_t enq_i,
    output logic                         almost_full_o,

    output logic                         dispatch_valid_o,
    output frontend_pkg::decoded_instr_t dispatch_o,
    input  wire                          dispatch_ready_i
);

    localparam frontend_pkg::iq_count_t COUNT_FULL =
        frontend_pkg::iq_count_t'(frontend_pkg::IQ_DEPTH);
    localparam frontend_pkg::iq_count_t COUNT_ALMOST_FULL =
        frontend_pkg::iq_count_t'(frontend_pkg::IQ_ALMOST_FULL);

    frontend_pkg::decoded_instr_t mem_q [frontend_pkg::IQ_DEPTH];
    frontend_pkg::iq_ptr_t        head_q;
    frontend_pkg::iq_ptr_t        tail_q;
    frontend_pkg::iq_count_t      count_q;
    logic                         empty;
    logic                         full;
    logic                         do_enq;
    logic                         do_deq;

    assign empty = (count_q == '0);
    assign full  = (count_q == COUNT_FULL);

    assign do_deq = !empty && dispatch_ready_i;
    // A full queue still takes an entry when the head leaves
    assign do_enq = enq_valid_i && (!full || dispatch_ready_i);

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[tail_q] <= enq_i;
        end
    end

    // ==================================================
    // Pointers and fill count
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= tail_q + 1'b1;   // Wraps at IQ_DEPTH
            end
            if (do_deq) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Throttles fetch before the queue can overflow
    assign almost_full_o = (count_q >= COUNT_ALMOST_FULL);

    assign dispatch_valid_o = !empty;
    assign dispatch_o       = mem_q[head_q];   // Head stays put until taken

endmodule

`default_nettype wire

//--- source/frontend_top.sv
// Instruction frontend top level
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
    input  wire                          clk,
    input  wire                          rst_n,

    // Instruction memory request
    output logic                         imem_req_valid_o,
    output frontend_pkg::addr_t          imem_req_addr_o,
    input  wire                          imem_req_ready_i,

    // Instruction memory response
    input  wire                          imem_resp_valid_i,
    input  rv_isa_pkg::instr_t           imem_resp_data_i,

    // Redirect
    input  wire                          redirect_i,
    input  frontend_pkg::addr_t          redirect_target_i,

    // Dispatch
    output logic                         dispatch_valid_o,
    output frontend_pkg::decoded_instr_t dispatch_o,
    input  wire                          dispatch_ready_i
);

    logic                         fetch_valid;
    frontend_pkg::fetch_pkt_t     fetch_pkt;
    logic                         dec_valid;
    frontend_pkg::decoded_instr_t dec;
    logic                         iq_almost_full;

    // ==================================================
    // Fetch -> decode -> queue
    // ==================================================
    fetch_unit u_fetch_unit (
        .clk               (clk),
        .rst_n             (rst_n),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .iq_almost_full_i  (iq_almost_full),
        .imem_req_valid_o  (imem_req_valid_o),
        .imem_req_addr_o   (imem_req_addr_o),
        .imem_req_ready_i  (imem_req_ready_i),
        .imem_resp_valid_i (imem_resp_valid_i),
        .imem_resp_data_i  (imem_resp_data_i),
        .fetch_valid_o     (fetch_valid),
        .fetch_pkt_o       (fetch_pkt)
    );

    instr_decode u_instr_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_i),   // Redirect empties the decode stage
        .fetch_valid_i (fetch_valid),
        .fetch_pkt_i   (fetch_pkt),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    instr_queue u_instr_queue (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (redirect_i),
        .enq_valid_i      (dec_valid),
        .enq_i            (dec),
        .almost_full_o    (iq_almost_full),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_o       (dispatch_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

endmodule

`default_nettype wire

//--- dv/frontend_chk.sv
// Frontend interface assertions
`timescale 1ns/1ns
`default_nettype none

module frontend_chk (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          imem_req_valid_o,
    input  frontend_pkg::addr_t          imem_req_addr_o,
    input  wire                          imem_req_ready_i,
    input  wire                          redirect_i,
    input  wire                          dispatch_valid_o,
    input  frontend_pkg::decoded_instr_t dispatch_o,
    input  wire                          dispatch_ready_i
);

    // Stalled dispatch keeps its payload
    property p_dispatch_stable;
        @(posedge clk) disable iff (!rst_n || redirect_i)
            dispatch_valid_o && !dispatch_ready_i |=> $stable(dispatch_o);
    endproperty

    // Unaccepted request keeps its address
    property p_req_addr_stable;
        @(posedge clk) disable iff (!rst_n || redirect_i)
            imem_req_valid_o && !imem_req_ready_i |=> $stable(imem_req_addr_o);
    endproperty

    a_dispatch_stable: assert property (p_dispatch_stable)
        else $error("dispatch payload changed while stalled");
    a_req_addr_stable: assert property (p_req_addr_stable)
        else $error("request address changed before acceptance");
    a_reset_release: assert property (@(posedge clk) $rose(rst_n) |-> !dispatch_valid_o)
        else $error("dispatch valid high right after reset");

endmodule

`default_nettype wire

//--- dv/frontend_tb.sv
// Instruction frontend testbench
`timescale 1ns/1ns
`default_nettype none

module frontend_tb;

    localparam int MAX_CYCLES = 6000;

    logic clk;
    logic rst_n;
    logic imem_req_valid_o;
    frontend_pkg::addr_t imem_req_addr_o;
    logic imem_req_ready_i;
    logic imem_resp_valid_i;
    rv_isa_pkg::instr_t imem_resp_data_i;
    logic redirect_i;
    frontend_pkg::addr_t redirect_target_i;
    logic dispatch_valid_o;
    frontend_pkg::decoded_instr_t dispatch_o;
    logic dispatch_ready_i;

    rv_isa_pkg::instr_t mem [256];
    frontend_pkg::decoded_instr_t got [$];
    logic [31:0] rng;
    int cycles;
    int req_cnt;   // Requests accepted since the last redirect
    // Memory model knobs
    logic ready_en;
    logic rand_delays;
    int fixed_lat;
    logic acc;
    frontend_pkg::addr_t acc_addr;
    logic pend;
    frontend_pkg::addr_t pend_addr;
    int wait_cnt;

    frontend_top u_frontend_top (.*);

    bind frontend_top frontend_chk u_frontend_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ==================================================
    // Memory model and dispatch monitor
    // ==================================================
    always @(posedge clk) begin
        acc      <= rst_n && imem_req_valid_o && imem_req_ready_i;
        acc_addr <= imem_req_addr_o;
        cycles   <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
        if (redirect_i) begin
            got.delete();   // Only the new stream counts
            req_cnt <= 0;
        end else begin
            if (rst_n && dispatch_valid_o && dispatch_ready_i) begin
                got.push_back(dispatch_o);
            end
            if (rst_n && imem_req_valid_o && imem_req_ready_i) begin
                req_cnt <= req_cnt + 1;
            end
        end
    end

    always @(negedge clk) begin
        imem_resp_valid_i = 1'b0;
        if (acc) begin
            pend      = 1'b1;
            pend_addr = acc_addr;
            rng       = xorshift(rng);
            wait_cnt  = rand_delays ? int'(rng % 4) : fixed_lat;
        end
        if (pend) begin
            if (wait_cnt == 0) begin
                imem_resp_valid_i = 1'b1;
                imem_resp_data_i  = mem[pend_addr[9:2]];
                pend              = 1'b0;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
        rng = xorshift(rng);
        imem_req_ready_i = ready_en && (!rand_delays || rng[3]);
    end

    // ==================================================
    // Reference model and checks
    // ==================================================
    function automatic frontend_pkg::decoded_instr_t expect_dec(input frontend_pkg::addr_t pc);
        frontend_pkg::decoded_instr_t d;
        rv_isa_pkg::instr_t w;
        logic [31:0] sx;
        w  = mem[pc[9:2]];
        sx = {32{w[31]}};
        d.pc    = pc;
        d.instr = w;
        case (w[6:0])
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_JALR:
                d.imm = (sx << 12) | 32'(w[31:20]);
            rv_isa_pkg::OPC_STORE:
                d.imm = (sx << 12) | (32'(w[31:25]) << 5) | 32'(w[11:7]);
            rv_isa_pkg::OPC_BRANCH:
                d.imm = (sx << 12) | (32'(w[7]) << 11) | (32'(w[30:25]) << 5)
                        | (32'(w[11:8]) << 1);
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
                d.imm = w & 32'hFFFF_F000;
            rv_isa_pkg::OPC_JAL:
                d.imm = (sx << 20) | (32'(w[19:12]) << 12) | (32'(w[20]) << 11)
                        | (32'(w[30:21]) << 1);
            default:
                d.imm = 32'h0;
        endcase
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.has_dest = (w[11:7] != 5'd0);
        return d;
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Wait for n dispatches, then compare against the sequential stream
    task automatic check_stream(input frontend_pkg::addr_t start, input int n);
        frontend_pkg::decoded_instr_t e;
        while (got.size() < n) @(posedge clk);
        for (int i = 0; i < n; i++) begin
            e = expect_dec(start + i * frontend_pkg::PC_STEP);
            check_val("dispatch pc", got[i].pc, e.pc);
            check_val("dispatch instr", got[i].instr, e.instr);
            check_val("dispatch imm", got[i].imm, e.imm);
            check_val("dispatch rd", 32'(got[i].rd), 32'(e.rd));
            check_val("dispatch rs1", 32'(got[i].rs1), 32'(e.rs1));
            check_val("dispatch rs2", 32'(got[i].rs2), 32'(e.rs2));
            check_val("dispatch has_dest", 32'(got[i].has_dest), 32'(e.has_dest));
        end
    endtask

    task automatic pulse_redirect(input frontend_pkg::addr_t target);
        @(negedge clk);
        redirect_i        = 1'b1;
        redirect_target_i = target;
        @(negedge clk);
        redirect_i        = 1'b0;
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic fetch_sequential();
        check_stream(32'h0, 40);
    endtask

    task automatic decode_fields();
        pulse_redirect(32'h200);
        check_stream(32'h200, 9);
        check_val("addi imm", got[0].imm, 32'hFFFF_FFFF);
        check_val("beq imm", got[2].imm, 32'hFFFF_FFFC);
        check_val("lui x0 has_dest", 32'(got[3].has_dest), 32'd0);
        check_val("add imm", got[8].imm, 32'd0);
    endtask

    task automatic hold_dispatch();
        @(negedge clk);
        dispatch_ready_i = 1'b0;
        pulse_redirect(32'h100);
        repeat (100) @(negedge clk);
        // Nothing dispatched yet, so every accepted fetch is buffered
        check_val("buffered within depth",
                  32'(req_cnt <= frontend_pkg::IQ_DEPTH), 32'd1);
        check_val("buffered up to almost full",
                  32'(req_cnt >= frontend_pkg::IQ_ALMOST_FULL), 32'd1);
        check_val("fetch stopped", 32'(imem_req_valid_o), 32'd0);
        dispatch_ready_i = 1'b1;
        check_stream(32'h100, 60);
    endtask

    task automatic redirect_in_flight();
        fixed_lat = 3;
        do @(posedge clk); while (!(imem_req_valid_o && imem_req_ready_i));
        pulse_redirect(32'h280);   // Response still outstanding here
        check_stream(32'h280, 20);
        fixed_lat = 0;
    endtask

    task automatic stall_memory();
        rand_delays = 1'b1;
        pulse_redirect(32'h0);
        check_stream(32'h0, 40);
        rand_delays = 1'b0;
    endtask

    task automatic measure_latency();
        int n;
        @(negedge clk);
        ready_en = 1'b0;
        pulse_redirect(32'h300);
        repeat (10) @(negedge clk);   // Stale responses drain and the queue empties
        ready_en = 1'b1;
        do @(posedge clk); while (!imem_resp_valid_i);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!dispatch_valid_o && n < 10);
        check_val("dispatch latency", n, 3);
    endtask

    initial begin
        rng = 32'd28629;
        for (int i = 0; i < 256; i++) begin
            rng = xorshift(rng);
            case (rng % 9)
                0: mem[i] = {rng[31:7], rv_isa_pkg::OPC_OP_IMM};
                1: mem[i] = {rng[31:7], rv_isa_pkg::OPC_LOAD};
                2: mem[i] = {rng[31:7], rv_isa_pkg::OPC_JALR};
                3: mem[i] = {rng[31:7], rv_isa_pkg::OPC_STORE};
                4: mem[i] = {rng[31:7], rv_isa_pkg::OPC_BRANCH};
                5: mem[i] = {rng[31:7], rv_isa_pkg::OPC_LUI};
                6: mem[i] = {rng[31:7], rv_isa_pkg::OPC_AUIPC};
                7: mem[i] = {rng[31:7], rv_isa_pkg::OPC_JAL};
                default: mem[i] = {rng[31:7], 7'b0110011};   // Register op without immediate
            endcase
        end
        // Hand-placed words at 0x200
        mem[128] = 32'hFFF3_0293;   // addi x5, x6, -1
        mem[129] = 32'h0071_2423;   // sw x7, 8(x2)
        mem[130] = 32'hFE20_8EE3;   // beq x1, x2, -4
        mem[131] = 32'h1234_5037;   // lui x0
        mem[132] = 32'h0010_00EF;   // jal x1, 2048
        mem[133] = 32'h8000_0197;   // auipc x3
        mem[134] = 32'hFF00_A203;   // lw x4, -16(x1)
        mem[135] = 32'h0000_8067;   // jalr x0, 0(x1)
        mem[136] = 32'h0000_0033;   // add x0, x0, x0

        rst_n = 1'b0;
        imem_req_ready_i = 1'b0;
        imem_resp_valid_i = 1'b0;
        imem_resp_data_i = '0;
        redirect_i = 1'b0;
        redirect_target_i = '0;
        dispatch_ready_i = 1'b1;
        ready_en = 1'b1;
        rand_delays = 1'b0;
        fixed_lat = 0;
        acc = 1'b0;
        acc_addr = '0;
        pend = 1'b0;
        pend_addr = '0;
        wait_cnt = 0;
        cycles = 0;
        req_cnt = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        fetch_sequential();
        decode_fields();
        hold_dispatch();
        redirect_in_flight();
        stall_memory();
        measure_latency();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/rv_isa_pkg.sv
common/frontend_pkg.sv
fetch/fetch_unit.sv
decode/instr_decode.sv
queue/instr_queue.sv
source/frontend_top.sv
dv/frontend_chk.sv
dv/frontend_tb.sv
